// ==== include/cabinet_defs.svh ====
// Cabinet I/O constants

`ifndef CABINET_DEFS_SVH
`define CABINET_DEFS_SVH

// Game identifiers
`define GAME_SDI        8'h01
`define GAME_HVCHAMP    8'h01   // Same table entry as SDI
`define GAME_PASSSHT    8'h02
`define GAME_BULLET     8'h11
`define GAME_PASSSHT2   8'h13
`define GAME_PASSSHT_J  8'h13
`define GAME_DUNKSHOT   8'h14
`define GAME_PASSSHT3   8'h18
`define GAME_DEFENSE    8'h19

// Address regions, bits 13:12
`define REGION_CTRL     2'd0
`define REGION_PORTS    2'd1
`define REGION_DIPS     2'd2
`define REGION_CUSTOM   2'd3

`define SUBSPACE_CUSTOM 2'd2    // Bits 9:8 inside region 3

// Trackball update every 2**6 line blanks
`define TRACK_PERIOD_BITS 6
`define TRACK_RESET_0   12'h10A
`define TRACK_RESET_1   12'h20B
`define TRACK_RESET_2   12'h30C
`define TRACK_RESET_3   12'h40D
`define TRACK_RESET_4   12'h50E
`define TRACK_RESET_5   12'h60F
`define TRACK_RESET_6   12'h701
`define TRACK_RESET_7   12'h802

`endif

// ==== logic/cabinet_pkg.sv ====
// Cabinet I/O types

`default_nettype none

package cabinet_pkg;

    // Port view of the CPU word address, bits 23:1
    typedef struct packed {
        logic [9:0] upper;      // A23..A14
        logic [1:0] region;     // A13..A12
        logic [1:0] gap_hi;     // A11..A10
        logic [1:0] subspace;   // A9..A8
        logic [4:0] gap_lo;     // A7..A3
        logic [1:0] reg_idx;    // A2..A1
    } port_view_t;

    // Trackball view of the same word
    typedef struct packed {
        logic [18:0] upper;     // A23..A5
        logic [2:0]  idx;       // A4..A2
        logic        half;      // A1
    } track_view_t;

    // One address, two decodes
    typedef union packed {
        port_view_t  port;
        track_view_t track;
    } io_addr_u;

endpackage

`default_nettype wire

// ==== logic/joystick_sorter.sv ====
// Joystick sorter

`timescale 1ns/100ps
`default_nettype none

`include "cabinet_defs.svh"

module joystick_sorter (
    input  wire        clk,
    input  wire        rst,
    input  wire  [7:0] game_id,
    input  wire  [7:0] joystick1,
    input  wire  [7:0] joystick2,
    input  wire  [7:0] joystick3,
    input  wire  [7:0] joystick4,
    input  wire  [3:0] start_button,
    input  wire  [3:0] coin_input,
    input  wire        service,
    input  wire        dip_test,
    input  wire  [1:0] port_sel,
    output logic [7:0] port_word,
    output logic [7:0] pass_word,
    output logic [7:0] sys_inputs
);

    logic       game_bullet;
    logic       game_pass;
    logic       game_dunk;
    logic [7:0] std1;
    logic [7:0] std2;
    logic [7:0] std3;
    logic [7:0] sort1, sort2, sort3;

    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    function automatic logic [7:0] pass_joy(input logic [7:0] joy);
        pass_joy = {joy[7:4], joy[1:0], joy[3:2]};
    endfunction

    // Game class, one cycle behind game_id
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_bullet <= 1'b0;
            game_pass   <= 1'b0;
            game_dunk   <= 1'b0;
        end else begin
            game_bullet <= game_id == `GAME_BULLET;
            game_pass   <= game_id == `GAME_PASSSHT || game_id == `GAME_PASSSHT2 ||
                           game_id == `GAME_PASSSHT3;
            game_dunk   <= game_id == `GAME_DUNKSHOT;
        end
    end

    assign sys_inputs = {2'b11, start_button[1:0], service, dip_test, coin_input[1:0]};

    // Standard order per player
    assign std1 = sort_joy(joystick1);
    assign std2 = sort_joy(joystick2);
    assign std3 = sort_joy(joystick3);

    // Bullet wants the nibbles swapped
    assign sort1 = game_bullet ? {std1[3:0], std1[7:4]} : std1;
    assign sort2 = game_bullet ? {std2[3:0], std2[7:4]} : std2;
    assign sort3 = {std3[3:0], std3[7:4]};

    always_comb begin
        case (port_sel)
            2'd0: begin
                port_word = sys_inputs;
                if (game_bullet) begin
                    port_word[7] = coin_input[2];
                    port_word[6] = start_button[2];
                end
                if (game_pass || game_dunk) port_word[7:6] = start_button[3:2];
            end
            2'd1: port_word = game_dunk ? {joystick4[5:4], joystick3[5:4],
                                           joystick2[5:4], joystick1[5:4]} : sort1;
            2'd2: port_word = game_bullet ? sort3 : 8'hFF;  // Third player on Bullet only
            default: port_word = sort2;
        endcase
    end

    always_comb begin
        case (port_sel)
            2'd0:    pass_word = pass_joy(joystick1);
            2'd1:    pass_word = pass_joy(joystick2);
            2'd2:    pass_word = pass_joy(joystick3);
            default: pass_word = pass_joy(joystick4);
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/trackball_counters.sv ====
// Trackball counters

`timescale 1ns/100ps
`default_nettype none

`include "cabinet_defs.svh"

module trackball_counters (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   lhbl,
    input  wire  [15:0]           joyana1,
    input  wire  [15:0]           joyana2,
    input  wire  [15:0]           joyana3,
    input  wire  [15:0]           joyana4,
    input  wire cabinet_pkg::io_addr_u track_sel,
    output logic [7:0]            track_word
);

    logic                          lhbl_q;
    logic                          fall;
    logic [`TRACK_PERIOD_BITS-1:0] line_cnt;
    logic [11:0]                   track [8];
    logic [7:0]                    axis [8];
    logic [11:0]                   sel_cnt;

    // Axis byte to 12-bit step, bit 7 as sign
    function automatic logic [11:0] ext_axis(input logic [7:0] ax);
        ext_axis = {{8{ax[7]}}, ax[6:3]};
    endfunction

    // Even counters take the low byte, odd ones the high byte
    assign axis[0] = joyana1[7:0];
    assign axis[1] = joyana1[15:8];
    assign axis[2] = joyana2[7:0];
    assign axis[3] = joyana2[15:8];
    assign axis[4] = joyana3[7:0];
    assign axis[5] = joyana3[15:8];
    assign axis[6] = joyana4[7:0];
    assign axis[7] = joyana4[15:8];

    assign fall = lhbl_q && !lhbl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_q   <= 1'b0;
            line_cnt <= '0;
            track[0] <= `TRACK_RESET_0;
            track[1] <= `TRACK_RESET_1;
            track[2] <= `TRACK_RESET_2;
            track[3] <= `TRACK_RESET_3;
            track[4] <= `TRACK_RESET_4;
            track[5] <= `TRACK_RESET_5;
            track[6] <= `TRACK_RESET_6;
            track[7] <= `TRACK_RESET_7;
        end else begin
            lhbl_q <= lhbl;
            if (fall) begin
                line_cnt <= line_cnt + 1'b1;
                if (line_cnt == '0) begin
                    for (int i = 0; i < 8; i++) begin
                        if (i % 2 == 1) track[i] <= track[i] + ext_axis(axis[i]);
                        else            track[i] <= track[i] - ext_axis(axis[i]);
                    end
                end
            end
        end
    end

    assign sel_cnt    = track[track_sel.track.idx];
    assign track_word = track_sel.track.half ? {4'd0, sel_cnt[11:8]} : sel_cnt[7:0];

    // Line count moves only on a blank falling edge
    a_cnt_on_edge: assert property (@(posedge clk) disable iff (rst)
        !fall |=> $stable(line_cnt));

endmodule

`default_nettype wire

// ==== logic/analog_serial_reader.sv ====
// Serial analog reader

`timescale 1ns/100ps
`default_nettype none

module analog_serial_reader (
    input  wire        clk,
    input  wire        rst,
    input  wire [15:0] joyana1,
    input  wire [15:0] joyana2,
    input  wire  [1:0] ana_sel,
    input  wire        ana_load,
    input  wire        ana_shift,
    output logic       ana_bit
);

    logic [8:0] ana_sum;
    logic [7:0] load_val;
    logic [7:0] shift_q;

    // Sign-extended sum of both high bytes
    assign ana_sum = {joyana1[15], joyana1[15:8]} + {joyana2[15], joyana2[15:8]};

    always_comb begin
        case (ana_sel)
            2'd0:    load_val = ana_sum[8:1];  // Average
            2'd1:    load_val = joyana1[15:8];
            2'd2:    load_val = joyana2[15:8];
            default: load_val = 8'hFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ana_load) begin
            shift_q <= load_val;
        end else if (ana_shift) begin
            shift_q <= {shift_q[6:0], 1'b0};  // MSB goes out first
        end
    end

    assign ana_bit = shift_q[7];

    // Decoder keeps write and read strobes apart
    a_no_load_shift: assert property (@(posedge clk) disable iff (rst)
        !(ana_load && ana_shift));

endmodule

`default_nettype wire

// ==== logic/io_decoder.sv ====
// Cabinet I/O decoder

`timescale 1ns/100ps
`default_nettype none

`include "cabinet_defs.svh"

module io_decoder (
    input  wire                        clk,
    input  wire                        rst,
    input  wire cabinet_pkg::io_addr_u addr,
    input  wire  [15:0]                cpu_dout,
    input  wire                        lds_n,
    input  wire                        uds_n,
    input  wire                        io_cs,
    input  wire  [7:0]                 game_id,
    input  wire  [7:0]                 dipsw_a,
    input  wire  [7:0]                 dipsw_b,
    input  wire  [15:0]                joyana1,
    input  wire  [15:0]                joyana2,
    input  wire  [15:0]                joyana3,
    input  wire  [15:0]                joyana4,
    input  wire  [7:0]                 port_word,
    input  wire  [7:0]                 pass_word,
    input  wire  [7:0]                 track_word,
    input  wire                        ana_bit,
    output logic [1:0]                 port_sel,
    output cabinet_pkg::io_addr_u      track_sel,
    output logic [1:0]                 ana_sel,
    output logic                       ana_load,
    output logic                       ana_shift,
    output logic [7:0]                 cab_dout,
    output logic                       flip,
    output logic                       video_en
);

    logic       io_cs_q;
    logic       custom_sub;
    logic       any_write;
    logic       hvchamp_acc;
    logic [7:0] rd_byte;

    assign port_sel = addr.port.reg_idx;
    assign ana_sel  = addr.port.reg_idx;

    always_comb begin
        track_sel            = '0;
        track_sel.track.idx  = addr.track.idx;
        track_sel.track.half = addr.track.half;
    end

    assign custom_sub  = addr.port.subspace == `SUBSPACE_CUSTOM;
    assign any_write   = !lds_n || !uds_n;
    assign hvchamp_acc = io_cs && addr.port.region == `REGION_CUSTOM && custom_sub &&
                         game_id == `GAME_HVCHAMP;

    // Load on write, shift once at the start of each read
    assign ana_load  = hvchamp_acc && any_write;
    assign ana_shift = hvchamp_acc && !any_write && !io_cs_q;

    always_comb begin
        rd_byte = 8'hFF;
        case (addr.port.region)
            `REGION_PORTS: rd_byte = port_word;
            `REGION_DIPS:  rd_byte = addr.port.reg_idx[0] ? dipsw_a : dipsw_b;
            `REGION_CUSTOM: begin
                // SDI shares id 1, so Heavy Champion takes it here
                if (game_id == `GAME_HVCHAMP) begin
                    if (ana_shift) rd_byte = {7'd0, ana_bit};
                end else if (game_id == `GAME_PASSSHT_J) begin
                    if (custom_sub) rd_byte = pass_word;
                end else if (game_id == `GAME_DUNKSHOT) begin
                    rd_byte = track_word;
                end else if (game_id == `GAME_SDI || game_id == `GAME_DEFENSE) begin
                    if (custom_sub) begin
                        case (addr.port.reg_idx)
                            2'd0:    rd_byte = joyana1[15:8];
                            2'd1:    rd_byte = joyana2[15:8];
                            2'd2:    rd_byte = joyana3[15:8];
                            default: rd_byte = joyana4[15:8];
                        endcase
                    end
                end
            end
            default: rd_byte = 8'hFF;  // Control region reads open bus
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_cs_q  <= 1'b0;
            cab_dout <= 8'hFF;
            flip     <= 1'b0;
            video_en <= 1'b1;
        end else begin
            io_cs_q  <= io_cs;
            cab_dout <= io_cs ? rd_byte : 8'hFF;
            if (io_cs && addr.port.region == `REGION_CTRL && !lds_n) begin
                flip     <= cpu_dout[6];
                video_en <= cpu_dout[5];
            end
        end
    end

    // Bus idles high between accesses
    a_idle_ff: assert property (@(posedge clk) disable iff (rst)
        !io_cs |=> cab_dout == 8'hFF);

endmodule

`default_nettype wire

// ==== logic/cabinet_io.sv ====
// Cabinet I/O top level

`timescale 1ns/100ps
`default_nettype none

module cabinet_io (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        lhbl,
    input  wire  [7:0]                 game_id,
    input  wire cabinet_pkg::io_addr_u addr,
    input  wire  [15:0]                cpu_dout,
    input  wire                        lds_n,
    input  wire                        uds_n,
    input  wire                        io_cs,
    input  wire                        dip_test,
    input  wire  [7:0]                 dipsw_a,
    input  wire  [7:0]                 dipsw_b,
    input  wire  [7:0]                 joystick1,
    input  wire  [7:0]                 joystick2,
    input  wire  [7:0]                 joystick3,
    input  wire  [7:0]                 joystick4,
    input  wire  [15:0]                joyana1,
    input  wire  [15:0]                joyana2,
    input  wire  [15:0]                joyana3,
    input  wire  [15:0]                joyana4,
    input  wire  [3:0]                 start_button,
    input  wire  [3:0]                 coin_input,
    input  wire                        service,
    output logic [7:0]                 sys_inputs,
    output logic [7:0]                 cab_dout,
    output logic                       flip,
    output logic                       video_en
);

    import cabinet_pkg::*;

    io_addr_u   track_sel;
    logic [1:0] port_sel;
    logic [1:0] ana_sel;
    logic       ana_load;
    logic       ana_shift;
    logic       ana_bit;
    logic [7:0] port_word;
    logic [7:0] pass_word;
    logic [7:0] track_word;

    joystick_sorter u_sorter (
        .clk(clk), .rst(rst), .game_id(game_id),
        .joystick1(joystick1), .joystick2(joystick2),
        .joystick3(joystick3), .joystick4(joystick4),
        .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test), .port_sel(port_sel),
        .port_word(port_word), .pass_word(pass_word), .sys_inputs(sys_inputs)
    );

    trackball_counters u_track (
        .clk(clk), .rst(rst), .lhbl(lhbl),
        .joyana1(joyana1), .joyana2(joyana2), .joyana3(joyana3), .joyana4(joyana4),
        .track_sel(track_sel), .track_word(track_word)
    );

    analog_serial_reader u_ana (
        .clk(clk), .rst(rst), .joyana1(joyana1), .joyana2(joyana2),
        .ana_sel(ana_sel), .ana_load(ana_load), .ana_shift(ana_shift),
        .ana_bit(ana_bit)
    );

    io_decoder u_dec (
        .clk(clk), .rst(rst), .addr(addr), .cpu_dout(cpu_dout),
        .lds_n(lds_n), .uds_n(uds_n), .io_cs(io_cs), .game_id(game_id),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .joyana1(joyana1), .joyana2(joyana2), .joyana3(joyana3), .joyana4(joyana4),
        .port_word(port_word), .pass_word(pass_word), .track_word(track_word),
        .ana_bit(ana_bit), .port_sel(port_sel), .track_sel(track_sel),
        .ana_sel(ana_sel), .ana_load(ana_load), .ana_shift(ana_shift),
        .cab_dout(cab_dout), .flip(flip), .video_en(video_en)
    );

endmodule

`default_nettype wire

// ==== verification/cabinet_tests.svh ====
// Cabinet I/O directed tests

`ifndef CABINET_TESTS_SVH
`define CABINET_TESTS_SVH

// Standard order is 1:0, 3:2, 7, 5:4, 6 from the top bit
function automatic logic [7:0] sorted_joy(input logic [7:0] j, input logic swap);
    logic [7:0] s;
    s = {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    sorted_joy = swap ? {s[3:0], s[7:4]} : s;
endfunction

function automatic logic [7:0] player(input int p);
    case (p)
        0:       player = joystick1;
        1:       player = joystick2;
        2:       player = joystick3;
        default: player = joystick4;
    endcase
endfunction

// Counter i follows joyana(i/2), low byte for even i
function automatic logic [7:0] axis_byte(input int i);
    logic [15:0] w;
    case (i / 2)
        0:       w = joyana1;
        1:       w = joyana2;
        2:       w = joyana3;
        default: w = joyana4;
    endcase
    axis_byte = (i % 2 == 1) ? w[15:8] : w[7:0];
endfunction

function automatic logic [7:0] expect_port(input logic [7:0] gid, input logic [1:0] r);
    logic       bullet;
    logic       pass;
    logic       dunk;
    logic [7:0] w;
    bullet = gid == `GAME_BULLET;
    pass   = gid == `GAME_PASSSHT || gid == `GAME_PASSSHT2 || gid == `GAME_PASSSHT3;
    dunk   = gid == `GAME_DUNKSHOT;
    case (r)
        2'd0: begin
            w = {2'b11, start_button[1:0], service, dip_test, coin_input[1:0]};
            if (bullet) w[7:6] = {coin_input[2], start_button[2]};
            if (pass || dunk) w[7:6] = start_button[3:2];
        end
        2'd1: w = dunk ? {joystick4[5:4], joystick3[5:4], joystick2[5:4], joystick1[5:4]}
                       : sorted_joy(joystick1, bullet);
        2'd2: w = bullet ? sorted_joy(joystick3, 1'b1) : 8'hFF;
        default: w = sorted_joy(joystick2, bullet);
    endcase
    expect_port = w;
endfunction

task automatic randomize_inputs();
    logic [7:0] r;
    joystick1 = rand8();
    joystick2 = rand8();
    joystick3 = rand8();
    joystick4 = rand8();
    joyana1   = {rand8(), rand8()};
    joyana2   = {rand8(), rand8()};
    joyana3   = {rand8(), rand8()};
    joyana4   = {rand8(), rand8()};
    {start_button, coin_input} = rand8();
    r        = rand8();
    service  = r[0];
    dip_test = r[1];
endtask

task automatic check_reset_state();
    check_val("flip", {7'd0, flip}, 8'h00);
    check_val("video_en", {7'd0, video_en}, 8'h01);
    check_val("cab_dout", cab_dout, 8'hFF);
endtask

task automatic control_latch();
    write_io(io_addr(`REGION_CTRL, 2'd0, 5'd0), 16'h0040, 1'b0, 1'b1);
    check_val("flip", {7'd0, flip}, 8'h01);
    check_val("video_en", {7'd0, video_en}, 8'h00);
    write_io(io_addr(`REGION_CTRL, 2'd0, 5'd0), 16'h0020, 1'b0, 1'b0);
    check_val("flip", {7'd0, flip}, 8'h00);
    check_val("video_en", {7'd0, video_en}, 8'h01);
    // Upper byte only, latch must hold
    write_io(io_addr(`REGION_CTRL, 2'd0, 5'd0), 16'h0040, 1'b1, 1'b0);
    check_val("flip", {7'd0, flip}, 8'h00);
    check_val("video_en", {7'd0, video_en}, 8'h01);
endtask

task automatic region1_ports();
    logic [7:0] games [3];
    logic [7:0] d;
    games = '{`GAME_SDI, `GAME_BULLET, `GAME_DUNKSHOT};
    for (int g = 0; g < 3; g++) begin
        randomize_inputs();
        set_game(games[g]);
        check_val("sys_inputs", sys_inputs,
                  {2'b11, start_button[1:0], service, dip_test, coin_input[1:0]});
        for (int r = 0; r < 4; r++) begin
            read_io(io_addr(`REGION_PORTS, 2'd0, 5'(r)), d);
            check_val("cab_dout region 1", d, expect_port(games[g], 2'(r)));
        end
    end
endtask

task automatic dips_and_custom();
    logic [7:0] d;
    logic [7:0] j;
    dipsw_a = rand8();
    dipsw_b = rand8();
    read_io(io_addr(`REGION_DIPS, 2'd0, 5'd1), d);  // A1 set picks bank A
    check_val("cab_dout dipsw_a", d, dipsw_a);
    read_io(io_addr(`REGION_DIPS, 2'd0, 5'd0), d);
    check_val("cab_dout dipsw_b", d, dipsw_b);
    set_game(`GAME_PASSSHT_J);
    for (int r = 0; r < 4; r++) begin
        j = player(r);
        read_io(io_addr(`REGION_CUSTOM, `SUBSPACE_CUSTOM, 5'(r)), d);
        check_val("cab_dout pass order", d, {j[7:4], j[1:0], j[3:2]});
    end
    set_game(`GAME_DEFENSE);
    for (int r = 0; r < 4; r++) begin
        read_io(io_addr(`REGION_CUSTOM, `SUBSPACE_CUSTOM, 5'(r)), d);
        check_val("cab_dout axis high", d, axis_byte(2 * r + 1));
    end
endtask

task automatic trackball_updates();
    logic [11:0] base [8];
    logic [11:0] val;
    logic [7:0]  ax;
    logic [7:0]  d;
    int          step;
    base = '{`TRACK_RESET_0, `TRACK_RESET_1, `TRACK_RESET_2, `TRACK_RESET_3,
             `TRACK_RESET_4, `TRACK_RESET_5, `TRACK_RESET_6, `TRACK_RESET_7};
    set_game(`GAME_DUNKSHOT);
    for (int i = 0; i < 8; i++) begin
        read_io(io_addr(`REGION_CUSTOM, 2'd0, {1'b0, 3'(i), 1'b0}), d);
        check_val("track low byte", d, base[i][7:0]);
        read_io(io_addr(`REGION_CUSTOM, 2'd0, {1'b0, 3'(i), 1'b1}), d);
        check_val("track high nibble", d, {4'd0, base[i][11:8]});
    end
    joyana1 = {rand8(), rand8()};
    joyana2 = {rand8(), rand8()};
    joyana3 = {rand8(), rand8()};
    joyana4 = {rand8(), rand8()};
    // 65 falling edges give updates at the first and the 65th
    repeat (65) begin
        lhbl = 1'b1;
        wait_cycles(32);
        lhbl = 1'b0;
        wait_cycles(32);
    end
    for (int i = 0; i < 8; i++) begin
        ax   = axis_byte(i);
        step = ax[7] ? int'(ax[6:3]) - 16 : int'(ax[6:3]);
        val  = base[i] + 12'((i % 2 == 1) ? 2 * step : -2 * step);
        read_io(io_addr(`REGION_CUSTOM, 2'd0, {1'b0, 3'(i), 1'b0}), d);
        check_val("track low byte", d, val[7:0]);
        read_io(io_addr(`REGION_CUSTOM, 2'd0, {1'b0, 3'(i), 1'b1}), d);
        check_val("track high nibble", d, {4'd0, val[11:8]});
    end
endtask

task automatic serial_analog();
    logic [7:0] h1;
    logic [7:0] h2;
    logic [7:0] expect_byte;
    logic [7:0] d;
    int         sum;
    set_game(`GAME_HVCHAMP);
    for (int sel = 0; sel < 4; sel++) begin
        h1  = joyana1[15:8];
        h2  = joyana2[15:8];
        sum = (h1[7] ? int'(h1) - 256 : int'(h1)) + (h2[7] ? int'(h2) - 256 : int'(h2));
        case (sel)
            0:       expect_byte = 8'(sum >>> 1);  // Signed average
            1:       expect_byte = h1;
            2:       expect_byte = h2;
            default: expect_byte = 8'hFF;
        endcase
        write_io(io_addr(`REGION_CUSTOM, `SUBSPACE_CUSTOM, 5'(sel)), 16'h0000, 1'b0, 1'b1);
        for (int b = 7; b >= 0; b--) begin
            read_io(io_addr(`REGION_CUSTOM, `SUBSPACE_CUSTOM, 5'd0), d);
            check_val("cab_dout serial bit", d, {7'd0, expect_byte[b]});
        end
    end
endtask

`endif

// ==== verification/cabinet_tb.sv ====
// Cabinet I/O testbench

`timescale 1ns/100ps
`default_nettype none

`include "cabinet_defs.svh"

module cabinet_tb;

    localparam int MAX_CYCLES = 6000;  // 70 line blanks of 64 cycles plus margin

    logic        clk;
    logic        rst;
    logic        lhbl;
    logic [7:0]  game_id;
    logic [22:0] addr;              // Word address, A23..A1
    logic [15:0] cpu_dout;
    logic        lds_n;
    logic        uds_n;
    logic        io_cs;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic [7:0]  joystick1;
    logic [7:0]  joystick2;
    logic [7:0]  joystick3;
    logic [7:0]  joystick4;
    logic [15:0] joyana1;
    logic [15:0] joyana2;
    logic [15:0] joyana3;
    logic [15:0] joyana4;
    logic [3:0]  start_button;
    logic [3:0]  coin_input;
    logic        service;
    logic [7:0]  sys_inputs;
    logic [7:0]  cab_dout;
    logic        flip;
    logic        video_en;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    cabinet_io UUT (
        .clk(clk), .rst(rst), .lhbl(lhbl), .game_id(game_id), .addr(addr),
        .cpu_dout(cpu_dout), .lds_n(lds_n), .uds_n(uds_n), .io_cs(io_cs),
        .dip_test(dip_test), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .joystick1(joystick1), .joystick2(joystick2),
        .joystick3(joystick3), .joystick4(joystick4),
        .joyana1(joyana1), .joyana2(joyana2), .joyana3(joyana3), .joyana4(joyana4),
        .start_button(start_button), .coin_input(coin_input), .service(service),
        .sys_inputs(sys_inputs), .cab_dout(cab_dout), .flip(flip), .video_en(video_en)
    );

    always #50 clk = ~clk;

    // Hard stop if a test never returns
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;  // Back to the drive point after the edge
    endtask

    task automatic check_val(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
        checks++;
        assert (actual === expected)
            else begin
                errors++;
                $display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
            end
    endtask

    function automatic logic [7:0] rand8();
        logic [31:0] r;
        r = $random(seed);
        rand8 = r[7:0];
    endfunction

    // Region A13:A12, sub-space A9:A8, low field A5..A1
    function automatic logic [22:0] io_addr(input logic [1:0] region, input logic [1:0] sub,
                                            input logic [4:0] low);
        io_addr = {10'd0, region, 2'b00, sub, 2'b00, low};
    endfunction

    task automatic set_game(input logic [7:0] id);
        game_id = id;
        wait_cycles(2);  // Sorter class settles a cycle later
    endtask

    // One-cycle read, then an idle cycle with the bus back at FF
    task automatic read_io(input logic [22:0] a, output logic [7:0] d);
        addr  = a;
        lds_n = 1'b1;
        uds_n = 1'b1;
        io_cs = 1'b1;
        wait_cycles(1);
        d     = cab_dout;
        io_cs = 1'b0;
        wait_cycles(1);
        check_val("cab_dout after access", cab_dout, 8'hFF);
    endtask

    task automatic write_io(input logic [22:0] a, input logic [15:0] data,
                            input logic lds, input logic uds);
        addr     = a;
        cpu_dout = data;
        lds_n    = lds;
        uds_n    = uds;
        io_cs    = 1'b1;
        wait_cycles(1);
        io_cs    = 1'b0;
        lds_n    = 1'b1;
        uds_n    = 1'b1;
        wait_cycles(1);
    endtask

    `include "cabinet_tests.svh"

    initial begin
        seed         = 31;
        clk          = 1'b0;
        rst          = 1'b1;
        lhbl         = 1'b0;  // Held low so no blank edge before the trackball test
        game_id      = 8'h00;
        addr         = '0;
        cpu_dout     = '0;
        lds_n        = 1'b1;
        uds_n        = 1'b1;
        io_cs        = 1'b0;
        dip_test     = 1'b0;
        dipsw_a      = 8'h00;
        dipsw_b      = 8'h00;
        joystick1    = 8'hFF;
        joystick2    = 8'hFF;
        joystick3    = 8'hFF;
        joystick4    = 8'hFF;
        joyana1      = '0;
        joyana2      = '0;
        joyana3      = '0;
        joyana4      = '0;
        start_button = 4'hF;
        coin_input   = 4'hF;
        service      = 1'b1;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;

        check_reset_state();
        control_latch();
        region1_ports();
        dips_and_custom();
        trackball_updates();
        serial_analog();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
+incdir+verification
logic/cabinet_pkg.sv
logic/joystick_sorter.sv
logic/trackball_counters.sv
logic/analog_serial_reader.sv
logic/io_decoder.sv
logic/cabinet_io.sv
verification/cabinet_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP = cabinet_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
		-f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
